// File: flist.f
logic/CsrPkg.sv
logic/SpiCtrlIf.sv
logic/PerfCounters.sv
logic/SpiMaster.sv
logic/IrqTimer.sv
logic/ControlRegs.sv
logic/CsrSubsystem.sv
dv/CsrSubsystemTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP = CsrSubsystemTb
FLIST = flist.f
OBJDIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: dv/CsrSubsystemTb.sv
`timescale 1ns/1ps

module CsrSubsystemTb import CsrPkg::*; ();

    localparam int PRESCALE_BITS = 2;
    localparam int NUM_LANES = 4;
    // Tests need roughly 1500 cycles
    localparam int WATCHDOG_CYCLES = 20000;
    localparam int KIND_VALUE = 0;
    localparam int KIND_FLAGS = 1;
    localparam int KIND_CAPTURE = 2;

    logic clk;
    logic rst;
    logic we;
    logic [3:0] wmask;
    logic [CSR_ADDR_W-1:0] writeAddr;
    logic [DATA_W-1:0] wdata;
    logic re;
    logic [CSR_ADDR_W-1:0] readAddr;
    logic [DATA_W-1:0] rdata;
    logic rdValid;
    logic irqTaken;
    logic [DATA_W-1:0] irqSrc;
    IrqFlags irqFlags;
    logic [DATA_W-1:0] irqMemAddr;
    logic [DATA_W-1:0] irqAddr;
    logic fetchValid [NUM_LANES];
    logic comValid [NUM_LANES];
    logic comBranch [NUM_LANES];
    logic wbValid [NUM_LANES];
    logic branchMispred;
    logic mispredFlush;
    logic spiCs;
    logic spiSclk;
    logic spiMosi;
    logic spiMiso;
    logic tmrIrq;
    logic ioBusy;

    integer seed = 32'hd06ebd65;
    int cycleCount;
    int lastStrobe;
    int pendingReads;
    int errorCount;
    int bitsSeen;
    logic [DATA_W-1:0] regModel [NUM_REGS];
    logic [63:0] perfModel [NUM_PERF];
    logic [DATA_W-1:0] mosiWord;
    logic [DATA_W-1:0] misoWord;

    // Outstanding reads, oldest first
    logic [DATA_W-1:0] expValQ [$];
    int expKindQ [$];
    string expNameQ [$];
    logic [DATA_W-1:0] capturedQ [$];

    CsrSubsystem #(
        .NUM_UOPS(NUM_LANES),
        .NUM_WBS(NUM_LANES),
        .TIMER_PRESCALE_BITS(PRESCALE_BITS)
    ) UUT (.*);

    function automatic logic [DATA_W-1:0] maskedWrite(input logic [DATA_W-1:0] old,
            input logic [DATA_W-1:0] data, input logic [3:0] mask);
        logic [DATA_W-1:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                result[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // Sent bits leave on the left, received bits enter on the right
    function automatic logic [DATA_W-1:0] spiResult(input logic [DATA_W-1:0] tx,
            input logic [DATA_W-1:0] rx, input int n);
        logic [63:0] lowMask;
        lowMask = (64'd1 << n) - 64'd1;
        return (tx << n) | (rx & lowMask[DATA_W-1:0]);
    endfunction

    function automatic int countSet(input logic [3:0] bits);
        return int'(bits[0]) + int'(bits[1]) + int'(bits[2]) + int'(bits[3]);
    endfunction

    function automatic int timerInterval(input int period, input int prescaleBits);
        return period * (1 << prescaleBits) + 1;
    endfunction

    function automatic logic [CSR_ADDR_W-1:0] perfAddress(input PerfIdx idx, input logic high);
        return {2'b01, 1'b0, idx, high};
    endfunction

    task automatic stopOnError(input string msg);
        errorCount++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkReg32(input logic [DATA_W-1:0] actual,
            input logic [DATA_W-1:0] expected, input string what);
        if (actual !== expected) begin
            stopOnError($sformatf("FAILED at %0t: %s is %h, expected %h",
                $time, what, actual, expected));
        end
    endtask

    task automatic checkFlags(input IrqFlags actual, input IrqFlags expected, input string what);
        if (actual !== expected) begin
            stopOnError($sformatf("FAILED at %0t: %s flags are %s, expected %s",
                $time, what, actual.name(), expected.name()));
        end
    endtask

    // Bit 17 and 18 together raise a flush, one cycle in four
    task automatic driveEvents(input logic [DATA_W-1:0] pattern);
        for (int i = 0; i < NUM_LANES; i++) begin
            fetchValid[i] = pattern[i];
            comValid[i] = pattern[4+i];
            comBranch[i] = pattern[8+i];
            wbValid[i] = pattern[12+i];
        end
        branchMispred = pattern[16];
        mispredFlush = pattern[17] & pattern[18];
    endtask

    task automatic writeReg(input logic [CSR_ADDR_W-1:0] addr, input logic [3:0] mask,
            input logic [DATA_W-1:0] data);
        @(posedge clk);
        #1;
        we = 1'b1;
        wmask = mask;
        writeAddr = addr;
        wdata = data;
        @(posedge clk);
        #1;
        we = 1'b0;
        if (!addr[ADDR_PERF_BIT]) begin
            regModel[addr[3:0]] = maskedWrite(regModel[addr[3:0]], data, mask);
        end
    endtask

    task automatic readReg(input logic [CSR_ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] expected, input int kind, input string what);
        expValQ.push_back(expected);
        expKindQ.push_back(kind);
        expNameQ.push_back(what);
        pendingReads++;
        @(posedge clk);
        #1;
        re = 1'b1;
        readAddr = addr;
        lastStrobe = cycleCount;
        @(posedge clk);
        #1;
        re = 1'b0;
        while (pendingReads != 0) begin
            @(posedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $fatal(1, "The tests did not finish");
    end

    // Every rdValid is matched against the oldest outstanding read
    initial begin
        int kind;
        logic [DATA_W-1:0] expected;
        string what;
        forever begin
            @(negedge clk);
            if (rdValid === 1'b1) begin
                if (pendingReads == 0) begin
                    stopOnError("rdValid pulsed with no read outstanding");
                end else begin
                    kind = expKindQ.pop_front();
                    expected = expValQ.pop_front();
                    what = expNameQ.pop_front();
                    if (kind == KIND_CAPTURE) begin
                        capturedQ.push_back(rdata);
                    end else if (kind == KIND_FLAGS) begin
                        // Address part and cause flags
                        checkReg32(rdata & ~32'h3, expected & ~32'h3, what);
                        checkFlags(IrqFlags'(rdata[1:0]), IrqFlags'(expected[1:0]), what);
                    end else begin
                        checkReg32(rdata, expected, what);
                    end
                    pendingReads--;
                end
            end
        end
    end

    // SPI slave, new miso bit after each rising sclk
    initial begin
        spiMiso = 1'b0;
        forever begin
            @(posedge spiSclk);
            if (spiCs !== 1'b0) begin
                stopOnError("SPI clock pulsed while chip select was high");
            end
            mosiWord = {mosiWord[DATA_W-2:0], spiMosi};
            misoWord = {misoWord[DATA_W-2:0], spiMiso};
            bitsSeen++;
            #1;
            spiMiso = 1'($random(seed));
        end
    end

    initial begin
        logic [DATA_W-1:0] rnd;
        logic [DATA_W-1:0] tx;
        logic [DATA_W-1:0] lowBits;
        logic [3:0] mask;
        int idx;
        int n;
        int firstStrobe;
        int cycles;
        int pulses;
        int pulseAt [3];

        rst = 1'b1;
        we = 1'b0;
        wmask = '0;
        writeAddr = '0;
        wdata = '0;
        re = 1'b0;
        readAddr = '0;
        irqTaken = 1'b0;
        irqSrc = '0;
        irqFlags = FLAGS_NONE;
        irqMemAddr = '0;
        driveEvents('0);
        errorCount = 0;
        pendingReads = 0;
        bitsSeen = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            regModel[i] = '0;
        end
        for (int i = 0; i < NUM_PERF; i++) begin
            perfModel[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        checkReg32(DATA_W'(spiCs), 32'd1, "spiCs after reset");
        checkReg32(DATA_W'(ioBusy), 32'd0, "ioBusy after reset");

        // Masked writes to the handler and scratch registers
        for (int t = 0; t < 40; t++) begin
            rnd = $random(seed);
            idx = (rnd[3:0] < 4'd5) ? 0 : int'(rnd[3:0]);
            mask = rnd[7:4];
            writeReg(CSR_ADDR_W'(idx), mask, $random(seed));
            readReg(CSR_ADDR_W'(idx), regModel[idx], KIND_VALUE, "masked register");
            checkReg32(irqAddr, regModel[REG_IRQ_HANDLER], "irqAddr");
        end

        // Interrupt capture
        for (int t = 0; t < 8; t++) begin
            @(posedge clk);
            #1;
            irqTaken = 1'b1;
            irqSrc = $random(seed);
            irqMemAddr = $random(seed);
            rnd = $random(seed);
            irqFlags = IrqFlags'(rnd[1:0]);
            @(posedge clk);
            #1;
            irqTaken = 1'b0;
            readReg(CSR_ADDR_W'(REG_IRQ_SRC), irqSrc, KIND_VALUE, "REG_IRQ_SRC");
            readReg(CSR_ADDR_W'(REG_IRQ_ADDR), (irqMemAddr & ~32'h3) | DATA_W'(irqFlags),
                KIND_FLAGS, "REG_IRQ_ADDR");
        end

        // Random core events, then quiet cycles so the fetch stage drains
        for (int t = 0; t < 200; t++) begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            driveEvents(rnd);
            perfModel[PERF_FETCHED] += 64'(countSet(rnd[3:0]));
            perfModel[PERF_EXECUTED] += 64'(countSet(rnd[15:12]));
            perfModel[PERF_MISPRED] += 64'(rnd[16]);
            if (!(rnd[17] && rnd[18])) begin
                perfModel[PERF_COMMITTED] += 64'(countSet(rnd[7:4]));
                perfModel[PERF_BRANCHES] += 64'(countSet(rnd[7:4] & rnd[11:8]));
            end
        end
        @(posedge clk);
        #1;
        driveEvents('0);
        repeat (3) @(posedge clk);
        for (int p = 1; p < NUM_PERF; p++) begin
            readReg(perfAddress(PerfIdx'(p), 1'b0), perfModel[p][31:0], KIND_VALUE,
                $sformatf("counter %0d low half", p));
            readReg(perfAddress(PerfIdx'(p), 1'b1), perfModel[p][63:32], KIND_VALUE,
                $sformatf("counter %0d high half", p));
        end
        readReg(perfAddress(PERF_CYCLES, 1'b0), '0, KIND_CAPTURE, "cycle counter");
        firstStrobe = lastStrobe;
        rnd = $random(seed);
        repeat (int'(rnd[3:0])) @(posedge clk);
        readReg(perfAddress(PERF_CYCLES, 1'b0), '0, KIND_CAPTURE, "cycle counter");
        checkReg32(capturedQ[1] - capturedQ[0], DATA_W'(lastStrobe - firstStrobe),
            "cycle counter distance");

        // SPI transfers of 8, 16 and 32 bits
        for (int s = 0; s < 3; s++) begin
            n = 8 << s;
            mask = (s == 0) ? 4'b1000 : ((s == 1) ? 4'b1100 : 4'b1111);
            bitsSeen = 0;
            writeReg(CSR_ADDR_W'(REG_SPI), mask, $random(seed));
            tx = regModel[REG_SPI];
            while (ioBusy !== 1'b1) begin
                @(posedge clk);
                #1;
            end
            while (ioBusy !== 1'b0) begin
                @(posedge clk);
                #1;
            end
            lowBits = DATA_W'((64'd1 << n) - 64'd1);
            checkReg32(DATA_W'(bitsSeen), DATA_W'(n), "SPI clock pulses");
            checkReg32(mosiWord & lowBits, tx >> (DATA_W - n), "mosi bits");
            checkReg32(DATA_W'(spiCs), 32'd1, "spiCs after transfer");
            regModel[REG_SPI] = spiResult(tx, misoWord, n);
            readReg(CSR_ADDR_W'(REG_SPI), regModel[REG_SPI], KIND_VALUE, "REG_SPI readback");
        end

        // Timer with a period of 3, then disabled
        writeReg(CSR_ADDR_W'(REG_TIMER), 4'b0011, 32'd3);
        pulses = 0;
        cycles = 0;
        while (pulses < 3) begin
            @(posedge clk);
            #1;
            cycles++;
            if (tmrIrq === 1'b1) begin
                pulseAt[pulses] = cycles;
                pulses++;
            end
        end
        for (int k = 1; k < 3; k++) begin
            checkReg32(DATA_W'(pulseAt[k] - pulseAt[k-1]),
                DATA_W'(timerInterval(3, PRESCALE_BITS)), "timer pulse interval");
        end
        writeReg(CSR_ADDR_W'(REG_TIMER), 4'b0011, 32'd0);
        repeat (2) @(posedge clk);
        for (int k = 0; k < 100; k++) begin
            @(posedge clk);
            #1;
            if (tmrIrq === 1'b1) begin
                stopOnError("Timer pulsed after its period was set to zero");
            end
        end

        if (errorCount == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Checks failed");
        end
    end

endmodule

// File: logic/CsrSubsystem.sv
`timescale 1ns/1ps

module CsrSubsystem import CsrPkg::*; #(
    parameter int NUM_UOPS = 4,
    parameter int NUM_WBS = 4,
    parameter int TIMER_PRESCALE_BITS = 10
) (
    input  logic clk,
    input  logic rst,

    // Register port
    input  logic we,
    input  logic [3:0] wmask,
    input  logic [CSR_ADDR_W-1:0] writeAddr,
    input  logic [DATA_W-1:0] wdata,
    input  logic re,
    input  logic [CSR_ADDR_W-1:0] readAddr,
    output logic [DATA_W-1:0] rdata,
    output logic rdValid,

    // Interrupt capture
    input  logic irqTaken,
    input  logic [DATA_W-1:0] irqSrc,
    input  IrqFlags irqFlags,
    input  logic [DATA_W-1:0] irqMemAddr,
    output logic [DATA_W-1:0] irqAddr,

    // Core events
    input  logic fetchValid [NUM_UOPS],
    input  logic comValid [NUM_UOPS],
    input  logic comBranch [NUM_UOPS],
    input  logic wbValid [NUM_WBS],
    input  logic branchMispred,
    input  logic mispredFlush,

    output logic spiCs,
    output logic spiSclk,
    output logic spiMosi,
    input  logic spiMiso,

    output logic tmrIrq,
    output logic ioBusy
);

    PerfIdx perfAddr;
    logic perfHigh;
    logic [DATA_W-1:0] perfData;

    SpiCtrlIf spiIf ();

    assign ioBusy = spiIf.busy;

    ControlRegs #(
        .TIMER_PRESCALE_BITS(TIMER_PRESCALE_BITS)
    ) regsBlock (
        .clk(clk),
        .rst(rst),
        .we(we),
        .wmask(wmask),
        .writeAddr(writeAddr),
        .wdata(wdata),
        .re(re),
        .readAddr(readAddr),
        .rdata(rdata),
        .rdValid(rdValid),
        .irqTaken(irqTaken),
        .irqSrc(irqSrc),
        .irqFlags(irqFlags),
        .irqMemAddr(irqMemAddr),
        .irqAddr(irqAddr),
        .perfAddr(perfAddr),
        .perfHigh(perfHigh),
        .perfData(perfData),
        .spi(spiIf.ctrl),
        .tmrIrq(tmrIrq)
    );

    PerfCounters #(
        .NUM_UOPS(NUM_UOPS),
        .NUM_WBS(NUM_WBS)
    ) perf (
        .clk(clk),
        .rst(rst),
        .fetchValid(fetchValid),
        .comValid(comValid),
        .comBranch(comBranch),
        .wbValid(wbValid),
        .branchMispred(branchMispred),
        .mispredFlush(mispredFlush),
        .sel(perfAddr),
        .high(perfHigh),
        .data(perfData)
    );

    SpiMaster spiEngine (
        .clk(clk),
        .rst(rst),
        .ctrl(spiIf.engine),
        .sclk(spiSclk),
        .mosi(spiMosi),
        .cs(spiCs),
        .miso(spiMiso)
    );

endmodule

// File: logic/ControlRegs.sv
`timescale 1ns/1ps

module ControlRegs import CsrPkg::*; #(
    parameter int TIMER_PRESCALE_BITS = 10
) (
    input  logic clk,
    input  logic rst,

    input  logic we,
    input  logic [3:0] wmask,
    input  logic [CSR_ADDR_W-1:0] writeAddr,
    input  logic [DATA_W-1:0] wdata,

    input  logic re,
    input  logic [CSR_ADDR_W-1:0] readAddr,
    output logic [DATA_W-1:0] rdata,
    output logic rdValid,

    input  logic irqTaken,
    input  logic [DATA_W-1:0] irqSrc,
    input  IrqFlags irqFlags,
    input  logic [DATA_W-1:0] irqMemAddr,
    output logic [DATA_W-1:0] irqAddr,

    // Counter half selected by the registered read address
    output PerfIdx perfAddr,
    output logic perfHigh,
    input  logic [DATA_W-1:0] perfData,

    SpiCtrlIf.ctrl spi,
    output logic tmrIrq
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    // Registered access port
    logic weReg;
    logic [3:0] wmaskReg;
    logic [CSR_ADDR_W-1:0] writeAddrReg;
    logic [DATA_W-1:0] wdataReg;
    logic reReg;
    logic [CSR_ADDR_W-1:0] readAddrReg;

    logic [3:0] writeIdx;
    logic regWrite;
    logic [BIT_COUNT_W-1:0] launchLen;
    logic startReg;
    logic [BIT_COUNT_W-1:0] bitCountReg;
    logic timerClear;

    assign writeIdx = writeAddrReg[3:0];
    assign regWrite = weReg && !writeAddrReg[ADDR_PERF_BIT];

    // Byte mask picks the SPI transfer length
    always_comb begin
        case (wmaskReg)
            4'b1111: launchLen = 6'd32;
            4'b1100: launchLen = 6'd16;
            4'b1000: launchLen = 6'd8;
            default: launchLen = 6'd0;
        endcase
    end

    assign timerClear = (regWrite && writeIdx == REG_TIMER && (|wmaskReg[1:0])) || irqTaken;

    IrqTimer #(
        .TIMER_PRESCALE_BITS(TIMER_PRESCALE_BITS)
    ) timer (
        .clk(clk),
        .rst(rst),
        .period(regs[REG_TIMER][15:0]),
        .clear(timerClear),
        .tick(tmrIrq)
    );

    assign irqAddr = regs[REG_IRQ_HANDLER];
    assign perfAddr = PerfIdx'(readAddrReg[3:1]);
    assign perfHigh = readAddrReg[0];

    assign spi.start = startReg;
    assign spi.bitCount = bitCountReg;
    assign spi.txData = regs[REG_SPI];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            weReg <= 1'b0;
            reReg <= 1'b0;
            rdValid <= 1'b0;
            startReg <= 1'b0;
        end else begin
            weReg <= we;
            reReg <= re;
            rdValid <= reReg;
            startReg <= regWrite && writeIdx == REG_SPI && launchLen != '0;

            // Shifted data follows the engine while it runs
            if (spi.busy) begin
                regs[REG_SPI] <= spi.rxData;
            end

            if (regWrite) begin
                for (int b = 0; b < 4; b++) begin
                    if (wmaskReg[b]) begin
                        regs[writeIdx][b*8 +: 8] <= wdataReg[b*8 +: 8];
                    end
                end
            end

            // Capture wins over a write in the same cycle
            if (irqTaken) begin
                regs[REG_IRQ_SRC] <= irqSrc;
                regs[REG_IRQ_ADDR] <= {irqMemAddr[DATA_W-1:2], irqFlags};
            end
        end
    end

    // Address, data and read result
    always_ff @(posedge clk) begin
        wmaskReg <= wmask;
        writeAddrReg <= writeAddr;
        wdataReg <= wdata;
        readAddrReg <= readAddr;
        bitCountReg <= launchLen;
        if (reReg) begin
            rdata <= readAddrReg[ADDR_PERF_BIT] ? perfData : regs[readAddrReg[3:0]];
        end
    end

    // Read data comes back exactly two edges after the strobe
    readLatency: assert property (
        @(posedge clk) disable iff (rst) rdValid |-> $past(re, 2)
    );

endmodule

// File: logic/IrqTimer.sv
`timescale 1ns/1ps

module IrqTimer #(
    parameter int TIMER_PRESCALE_BITS = 10
) (
    input  logic clk,
    input  logic rst,
    input  logic [15:0] period,
    input  logic clear,
    output logic tick
);

    localparam int CNT_W = 16 + TIMER_PRESCALE_BITS;

    logic [CNT_W-1:0] count;
    logic hit;

    // Upper bits count prescaled periods
    assign hit = (period != 16'd0) && (count[CNT_W-1:TIMER_PRESCALE_BITS] == period);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            tick <= 1'b0;
        end else begin
            tick <= hit;
            if (hit || clear) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // A zero period disables the timer
    noTickWithoutPeriod: assert property (
        @(posedge clk) disable iff (rst) tick |-> ($past(period) != 16'd0)
    );

endmodule

// File: logic/SpiMaster.sv
`timescale 1ns/1ps

module SpiMaster import CsrPkg::*; (
    input  logic clk,
    input  logic rst,

    SpiCtrlIf.engine ctrl,

    output logic sclk,
    output logic mosi,
    output logic cs,
    input  logic miso
);

    SpiState state;
    logic [BIT_COUNT_W-1:0] bitsLeft;
    logic [DATA_W-1:0] shiftReg;

    assign ctrl.rxData = shiftReg;
    assign ctrl.busy = (state != SPI_IDLE);

    // Each bit is one low and one high sclk cycle, MSB first
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SPI_IDLE;
            bitsLeft <= '0;
            sclk <= 1'b0;
            cs <= 1'b1;
            mosi <= 1'b0;
        end else if (ctrl.start) begin
            // Restart even when a transfer is running
            state <= SPI_LOW;
            bitsLeft <= ctrl.bitCount;
            sclk <= 1'b0;
            cs <= 1'b0;
            mosi <= ctrl.txData[DATA_W-1];
        end else begin
            case (state)
                SPI_LOW: begin
                    sclk <= 1'b1;
                    bitsLeft <= bitsLeft - 1'b1;
                    state <= SPI_HIGH;
                end
                SPI_HIGH: begin
                    sclk <= 1'b0;
                    if (bitsLeft == '0) begin
                        cs <= 1'b1;
                        state <= SPI_IDLE;
                    end else begin
                        // Next bit goes out on the falling edge
                        mosi <= shiftReg[DATA_W-1];
                        state <= SPI_LOW;
                    end
                end
                default: begin
                    sclk <= 1'b0;
                    cs <= 1'b1;
                end
            endcase
        end
    end

    // Shift data has no reset
    always_ff @(posedge clk) begin
        if (ctrl.start) begin
            shiftReg <= ctrl.txData;
        end else if (state == SPI_LOW) begin
            // Sample miso as sclk rises
            shiftReg <= {shiftReg[DATA_W-2:0], miso};
        end
    end

    csHighWhenIdle: assert property (
        @(posedge clk) disable iff (rst) (state == SPI_IDLE) |-> cs
    );

endmodule

// File: logic/PerfCounters.sv
`timescale 1ns/1ps

module PerfCounters import CsrPkg::*; #(
    parameter int NUM_UOPS = 4,
    parameter int NUM_WBS = 4
) (
    input  logic clk,
    input  logic rst,

    input  logic fetchValid [NUM_UOPS],
    input  logic comValid [NUM_UOPS],
    input  logic comBranch [NUM_UOPS],
    input  logic wbValid [NUM_WBS],
    input  logic branchMispred,
    input  logic mispredFlush,

    input  PerfIdx sel,
    input  logic high,
    output logic [DATA_W-1:0] data
);

    logic [63:0] counters [NUM_PERF];

    // Fetch valids arrive one cycle early
    logic fetchReg [NUM_UOPS];

    logic [63:0] fetchInc;
    logic [63:0] execInc;
    logic [63:0] comInc;
    logic [63:0] branchInc;

    // Per-cycle event totals
    always_comb begin
        fetchInc = '0;
        execInc = '0;
        comInc = '0;
        branchInc = '0;
        for (int i = 0; i < NUM_UOPS; i++) begin
            fetchInc = fetchInc + 64'(fetchReg[i]);
            comInc = comInc + 64'(comValid[i]);
            branchInc = branchInc + 64'(comValid[i] && comBranch[i]);
        end
        for (int i = 0; i < NUM_WBS; i++) begin
            execInc = execInc + 64'(wbValid[i]);
        end
        // Squashed commits are not counted
        if (mispredFlush) begin
            comInc = '0;
            branchInc = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PERF; i++) begin
                counters[i] <= '0;
            end
            for (int i = 0; i < NUM_UOPS; i++) begin
                fetchReg[i] <= 1'b0;
            end
        end else begin
            fetchReg <= fetchValid;
            counters[PERF_CYCLES] <= counters[PERF_CYCLES] + 64'd1;
            counters[PERF_FETCHED] <= counters[PERF_FETCHED] + fetchInc;
            counters[PERF_EXECUTED] <= counters[PERF_EXECUTED] + execInc;
            counters[PERF_COMMITTED] <= counters[PERF_COMMITTED] + comInc;
            counters[PERF_MISPRED] <= counters[PERF_MISPRED] + 64'(branchMispred);
            counters[PERF_BRANCHES] <= counters[PERF_BRANCHES] + branchInc;
        end
    end

    // Indices 6 and 7 read as zero
    always_comb begin
        data = '0;
        if (int'(sel) < NUM_PERF) begin
            data = high ? counters[sel][63:32] : counters[sel][31:0];
        end
    end

endmodule

// File: logic/SpiCtrlIf.sv
`timescale 1ns/1ps

// Launch and result path between the register block and the SPI engine
interface SpiCtrlIf import CsrPkg::*; ();

    // Single-cycle launch strobe, a new one restarts a running transfer
    logic start;
    logic [BIT_COUNT_W-1:0] bitCount;
    logic [DATA_W-1:0] txData;

    // Shift register contents, valid while busy
    logic [DATA_W-1:0] rxData;
    logic busy;

    modport ctrl (
        output start,
        output bitCount,
        output txData,
        input  rxData,
        input  busy
    );

    modport engine (
        input  start,
        input  bitCount,
        input  txData,
        output rxData,
        output busy
    );

endinterface

// File: logic/CsrPkg.sv
package CsrPkg;

    // Register port widths
    localparam int CSR_ADDR_W = 7;
    localparam int DATA_W = 32;

    // Bit 5 of an address selects the performance counters
    localparam int ADDR_PERF_BIT = 5;

    localparam int NUM_REGS = 16;
    localparam int NUM_PERF = 6;

    // Wide enough for a 32-bit transfer length
    localparam int BIT_COUNT_W = 6;

    // 32-bit register indices, 5 to 15 are scratch
    typedef enum logic [3:0] {
        REG_IRQ_HANDLER = 4'd0,
        REG_IRQ_SRC     = 4'd1,
        REG_IRQ_ADDR    = 4'd2,
        REG_TIMER       = 4'd3,
        REG_SPI         = 4'd4
    } CsrReg;

    // Interrupt cause, stored in the low bits of REG_IRQ_ADDR
    typedef enum logic [1:0] {
        FLAGS_NONE,
        FLAGS_BRK,
        FLAGS_TRAP,
        FLAGS_EXCEPT
    } IrqFlags;

    typedef enum logic [2:0] {
        PERF_CYCLES,
        PERF_FETCHED,
        PERF_EXECUTED,
        PERF_COMMITTED,
        PERF_MISPRED,
        PERF_BRANCHES
    } PerfIdx;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_LOW,
        SPI_HIGH
    } SpiState;

endpackage
